// ==== tb.f ====
+incdir+tb
design/l2_pkg.sv
design/l2_fifo.sv
design/l1_arbiter.sv
design/l2_memory.sv
design/l2_subsystem.sv
tb/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds tb_top with Verilator, runs it and checks the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_top -f tb.f -o tb_sim || exit 1
sim_output="$(./obj_dir/tb_sim)"
echo "$sim_output"
echo "$sim_output" | grep -qx "STATUS: PASS" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== tb/tb_tests.svh ====
/* Directed tests included into the body of tb_top. A read predicts its data
   from the shadow when its ack is seen; every wait gives up after wait_limit. */

////////////////////
// Model and checks

// Lanes with be set take the new byte
function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] lane_mask;
    lane_mask = '0;
    // Widen each enable to a full byte lane
    for (int b = 0; b < BE_W; b++) begin
        lane_mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_word & ~lane_mask) | (new_word & lane_mask);
endfunction

task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                           input logic [DATA_W-1:0] expected);
    assert (actual === expected)
    else begin
        $display("CHECK FAILED at time %0t: %s is 0x%08h, expected 0x%08h",
                 $time, name, actual, expected);
        error_count++;
    end
endtask

task automatic begin_test();
    test_error_mark = error_count;
endtask

task automatic end_test(input string name);
    if (error_count == test_error_mark) begin
        tests_passed++;
        $display("Test %s finished: ok", name);
    end else begin
        tests_failed++;
        $display("Test %s finished: %0d errors", name, error_count - test_error_mark);
    end
endtask

// Predicted returns of the current test not yet observed
function automatic bit returns_missing();
    return ((dcache_got.size() - dcache_got_pos) < (dcache_exp.size() - dcache_exp_pos))
           || ((icache_got.size() - icache_got_pos) < (icache_exp.size() - icache_exp_pos));
endfunction

////////////////////
// Requester side

// Request stays high after the ack until the caller drops it
task automatic issue_request(input logic [SUB_ID_W-1:0] id, input logic rnw,
                             input logic [ADDR_W-1:0] byte_addr, input logic [BE_W-1:0] be,
                             input logic [DATA_W-1:0] wdata, output int ack_cycle);
    int                    waited;
    logic [MEM_ADDR_W-1:0] idx;
    waited = 0;
    ack_cycle = -1;
    idx = byte_addr[MEM_ADDR_W+1:2];
    @(negedge clk);
    request[id] = 1'b1;
    l1_req[id] = '{addr: byte_addr, rnw: rnw, be: be, data: wdata};
    // Sample mid low phase clear of both edges
    #1;
    while (!ack[id] && waited < wait_limit) begin
        @(negedge clk);
        #1;
        waited++;
    end
    stall_cycles += waited;
    if (!ack[id]) begin
        $display("Timeout: requester %0d got no ack within %0d cycles", id, wait_limit);
        error_count++;
    end else begin
        ack_cycle = cycle_count;
        // Taken at the coming edge in order behind earlier requests
        if (!rnw) begin
            shadow[idx] = merge_bytes(shadow[idx], wdata, be);
        end else if (id == dcache) begin
            dcache_exp.push_back(shadow[idx]);
        end else begin
            icache_exp.push_back(shadow[idx]);
        end
    end
endtask

task automatic release_request(input logic [SUB_ID_W-1:0] id);
    @(negedge clk);
    request[id] = 1'b0;
endtask

// Wait for every predicted return and compare in acceptance order
task automatic drain_returns();
    int waited;
    waited = 0;
    while (returns_missing() && waited < wait_limit) begin
        @(posedge clk);
        waited++;
    end
    if (returns_missing()) begin
        $display("Timeout: read data still missing after %0d cycles", wait_limit);
        error_count++;
    end
    // Extra returns would land here
    repeat (4) @(posedge clk);
    check_value("data_valid[0] count", dcache_got.size() - dcache_got_pos,
                dcache_exp.size() - dcache_exp_pos);
    check_value("data_valid[1] count", icache_got.size() - icache_got_pos,
                icache_exp.size() - icache_exp_pos);
    while (dcache_got_pos < dcache_got.size() && dcache_exp_pos < dcache_exp.size()) begin
        check_value("data with data_valid[0]", dcache_got[dcache_got_pos],
                    dcache_exp[dcache_exp_pos]);
        dcache_got_pos++;
        dcache_exp_pos++;
    end
    while (icache_got_pos < icache_got.size() && icache_exp_pos < icache_exp.size()) begin
        check_value("data with data_valid[1]", icache_got[icache_got_pos],
                    icache_exp[icache_exp_pos]);
        icache_got_pos++;
        icache_exp_pos++;
    end
    // Resync so one bad test leaves the next alone
    dcache_got_pos = dcache_got.size();
    dcache_exp_pos = dcache_exp.size();
    icache_got_pos = icache_got.size();
    icache_exp_pos = icache_exp.size();
endtask

////////////////////
// Directed tests

task automatic write_then_read();
    int cycle;
    begin_test();
    issue_request(dcache, 1'b0, 32'h40, 4'hf, random_bits(32), cycle);
    issue_request(dcache, 1'b1, 32'h40, 4'h0, '0, cycle);
    release_request(dcache);
    // Count check also covers data_valid[1] staying low
    drain_returns();
    end_test("write_then_read");
endtask

task automatic byte_enable_merge();
    int cycle;
    begin_test();
    issue_request(dcache, 1'b0, 32'h60, 4'hf, random_bits(32), cycle);
    issue_request(dcache, 1'b0, 32'h60, 4'b0101, random_bits(32), cycle);
    issue_request(dcache, 1'b1, 32'h60, 4'h0, '0, cycle);
    release_request(dcache);
    drain_returns();
    end_test("byte_enable_merge");
endtask

task automatic priority_and_routing();
    int dcache_ack;
    int icache_ack;
    begin_test();
    issue_request(dcache, 1'b0, 32'h80, 4'hf, random_bits(32), dcache_ack);
    issue_request(dcache, 1'b0, 32'h84, 4'hf, random_bits(32), dcache_ack);
    release_request(dcache);
    // Both raise request on the same falling edge
    fork
        begin
            issue_request(dcache, 1'b1, 32'h80, 4'h0, '0, dcache_ack);
            release_request(dcache);
        end
        begin
            issue_request(icache, 1'b1, 32'h84, 4'h0, '0, icache_ack);
            release_request(icache);
        end
    join
    assert (dcache_ack < icache_ack)
    else begin
        $display("Priority broken: requester 1 acked in cycle %0d, requester 0 in cycle %0d",
                 icache_ack, dcache_ack);
        error_count++;
    end
    drain_returns();
    end_test("priority_and_routing");
endtask

task automatic back_pressure_stream();
    int cycle;
    begin_test();
    stall_cycles = 0;
    // FIFOs fill since the memory drains one request per two cycles
    for (int k = 0; k < 10; k++) begin
        issue_request(dcache, 1'b0, 32'h200 | 32'(k * 4), 4'hf, random_bits(32), cycle);
    end
    release_request(dcache);
    assert (stall_cycles > 0)
    else begin
        $display("Back-pressure never seen: all ten writes were acked without waiting");
        error_count++;
    end
    for (int k = 0; k < 10; k++) begin
        issue_request(dcache, 1'b1, 32'h200 | 32'(k * 4), 4'h0, '0, cycle);
    end
    release_request(dcache);
    drain_returns();
    end_test("back_pressure_stream");
endtask

task automatic mixed_random_traffic();
    logic [ADDR_W-1:0] d_addr [40];
    logic              d_rnw [40];
    logic [BE_W-1:0]   d_be [40];
    logic [DATA_W-1:0] d_data [40];
    logic [ADDR_W-1:0] i_addr [40];
    int                d_count;
    int                i_count;
    int                cycle_d;
    int                cycle_i;
    logic [1:0]        kind;
    logic [3:0]        idx;
    begin_test();
    d_count = 0;
    i_count = 0;
    // Every word in the window written once before any read
    for (int k = 0; k < 16; k++) begin
        issue_request(dcache, 1'b0, 32'h300 | 32'(k * 4), 4'hf, random_bits(32), cycle_d);
    end
    release_request(dcache);
    // Kinds 0 and 1 store while 2 reads data and 3 reads instructions
    for (int k = 0; k < 40; k++) begin
        kind = 2'(random_bits(2));
        idx = 4'(random_bits(4));
        if (kind == 2'd3) begin
            i_addr[i_count] = 32'h300 | {26'h0, idx, 2'b00};
            i_count++;
        end else begin
            d_addr[d_count] = 32'h300 | {26'h0, idx, 2'b00};
            d_rnw[d_count] = (kind == 2'd2);
            d_be[d_count] = 4'(random_bits(4));
            d_data[d_count] = random_bits(32);
            d_count++;
        end
    end
    fork
        begin
            for (int k = 0; k < d_count; k++) begin
                issue_request(dcache, d_rnw[k], d_addr[k], d_be[k], d_data[k], cycle_d);
                // Idle cycle lets the instruction cache win
                release_request(dcache);
            end
        end
        begin
            for (int k = 0; k < i_count; k++) begin
                issue_request(icache, 1'b1, i_addr[k], 4'h0, '0, cycle_i);
            end
            release_request(icache);
        end
    join
    drain_returns();
    end_test("mixed_random_traffic");
endtask

// ==== tb/tb_top.sv ====
/* Testbench for l2_subsystem. The L2 array is never cleared, so every read
   targets a word written earlier in the run. */
module tb_top;
    import l2_pkg::*;

    ////////////////////
    // DUT signals

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic [L1_CONNECTIONS-1:0] request;
    l1_request_array_t         l1_req;
    logic [L1_CONNECTIONS-1:0] ack;
    logic [L1_CONNECTIONS-1:0] data_valid;
    logic [DATA_W-1:0]         data;

    // Requester indices at index width
    logic [SUB_ID_W-1:0] dcache = SUB_ID_W'(L1_DCACHE_ID);
    logic [SUB_ID_W-1:0] icache = SUB_ID_W'(L1_ICACHE_ID);

    // Cycles any single wait may take
    int wait_limit = 200;

    ////////////////////
    // Reference model

    // Shadow of the L2 array, moved in acceptance order
    logic [DATA_W-1:0] shadow [2**MEM_ADDR_W];
    // Predicted and observed read data per requester
    logic [DATA_W-1:0] dcache_exp [$];
    logic [DATA_W-1:0] icache_exp [$];
    logic [DATA_W-1:0] dcache_got [$];
    logic [DATA_W-1:0] icache_got [$];
    // Entries already compared
    int dcache_exp_pos = 0;
    int icache_exp_pos = 0;
    int dcache_got_pos = 0;
    int icache_got_pos = 0;

    logic [15:0] lfsr_state = 16'd34802;
    int cycle_count = 0;
    // Cycles a request waited for its ack
    int stall_cycles = 0;
    int error_count = 0;
    int test_error_mark = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    l2_subsystem dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .request    (request),
        .l1_req     (l1_req),
        .ack        (ack),
        .data_valid (data_valid),
        .data       (data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Returns are registered, settled by the falling edge
    always @(negedge clk) begin
        if (data_valid[L1_DCACHE_ID]) begin
            dcache_got.push_back(data);
        end
        if (data_valid[L1_ICACHE_ID]) begin
            icache_got.push_back(data);
        end
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11, one step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int n = 0; n < count; n++) begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    `include "tb_tests.svh"

    initial begin
        rst_n = 1'b0;
        request = '0;
        l1_req = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        write_then_read();
        byte_enable_merge();
        priority_and_routing();
        back_pressure_stream();
        mixed_random_traffic();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/l2_subsystem.sv ====
/* L2 subsystem top: arbiter, request and write-data FIFOs, memory model.
   Reads return in acceptance order; latency depends on FIFO occupancy. */
module l2_subsystem (
    input  logic                              clk,
    input  logic                              rst_n,

    // L1 requesters
    input  logic [l2_pkg::L1_CONNECTIONS-1:0] request,
    input  l2_pkg::l1_request_array_t         l1_req,
    output logic [l2_pkg::L1_CONNECTIONS-1:0] ack,

    // Read returns
    output logic [l2_pkg::L1_CONNECTIONS-1:0] data_valid,
    output logic [l2_pkg::DATA_W-1:0]         data
);
    import l2_pkg::*;

    ////////////////////
    // Interconnect

    // Arbiter to request FIFO
    logic        request_push;
    logic        request_full;
    l2_request_t l2_req;

    // Arbiter to write-data FIFO
    logic              wr_data_push;
    logic              data_full;
    logic [DATA_W-1:0] wr_data;

    // FIFO heads to memory
    logic              req_valid;
    l2_request_t       req_head;
    logic              req_pop;
    logic              wr_valid;
    logic [DATA_W-1:0] wr_head;
    logic              wr_pop;

    // Memory back to arbiter
    logic       rd_valid;
    l2_return_t rd_return;

    ////////////////////
    // Instances

    l1_arbiter arbiter_i (
        .request      (request),
        .l1_req       (l1_req),
        .ack          (ack),
        .request_full (request_full),
        .data_full    (data_full),
        .request_push (request_push),
        .l2_req       (l2_req),
        .wr_data_push (wr_data_push),
        .wr_data      (wr_data),
        .rd_valid     (rd_valid),
        .rd_return    (rd_return),
        .data_valid   (data_valid),
        .data         (data)
    );

    // Address and control
    l2_fifo #(.payload_t(l2_request_t)) request_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (request_push),
        .push_data (l2_req),
        .full      (request_full),
        .pop       (req_pop),
        .valid     (req_valid),
        .pop_data  (req_head)
    );

    // Store words only
    l2_fifo #(.payload_t(logic [DATA_W-1:0])) data_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (wr_data_push),
        .push_data (wr_data),
        .full      (data_full),
        .pop       (wr_pop),
        .valid     (wr_valid),
        .pop_data  (wr_head)
    );

    l2_memory memory_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req_head),
        .req_pop   (req_pop),
        .wr_valid  (wr_valid),
        .wr_data   (wr_head),
        .wr_pop    (wr_pop),
        .rd_valid  (rd_valid),
        .rd_return (rd_return)
    );

endmodule

// ==== design/l2_memory.sv ====
/* L2 memory model, 256 words, two-cycle access, one request per two cycles.
   Array is not cleared at reset; reads of unwritten words return garbage. */
module l2_memory (
    input  logic                      clk,
    input  logic                      rst_n,

    // Request FIFO head
    input  logic                      req_valid,
    input  l2_pkg::l2_request_t       req,
    output logic                      req_pop,

    // Write-data FIFO head
    input  logic                      wr_valid,
    input  logic [l2_pkg::DATA_W-1:0] wr_data,
    output logic                      wr_pop,

    // Tagged read return, never stalled
    output logic                      rd_valid,
    output l2_pkg::l2_return_t        rd_return
);
    import l2_pkg::*;

    typedef enum logic {
        STATE_IDLE,
        STATE_ACCESS
    } state_t;

    state_t state;

    // Word array
    logic [DATA_W-1:0] mem [2**MEM_ADDR_W];

    // Low bits of the word address pick the entry
    logic [MEM_ADDR_W-1:0] word_idx;

    // Request taken this cycle
    logic start;
    logic start_write;
    logic start_read;

    ////////////////////
    // Request acceptance

    assign word_idx = req.addr[MEM_ADDR_W-1:0];

    // Stores wait until their data word is at the FIFO head
    assign start = (state == STATE_IDLE) & req_valid & (req.rnw | wr_valid);
    assign start_write = start & ~req.rnw;
    assign start_read = start & req.rnw;

    // Pop request always, data only for a store
    assign req_pop = start;
    assign wr_pop = start_write;

    ////////////////////
    // Control state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= STATE_IDLE;
            rd_valid <= 1'b0;
        end else begin
            case (state)
                STATE_IDLE: begin
                    if (start) begin
                        state <= STATE_ACCESS;
                    end
                end
                // Second cycle, no pop here
                STATE_ACCESS: state <= STATE_IDLE;
                default: state <= STATE_IDLE;
            endcase
            // Read data shows up one cycle after the pop
            rd_valid <= start_read;
        end
    end

    ////////////////////
    // Array access

    // Byte-lane merge, lands at end of the pop cycle
    always_ff @(posedge clk) begin
        if (start_write) begin
            for (int b = 0; b < BE_W; b++) begin
                if (req.be[b]) begin
                    mem[word_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // Return payload, held until the next read
    always_ff @(posedge clk) begin
        if (start_read) begin
            rd_return.data <= mem[word_idx];
            rd_return.sub_id <= req.sub_id;
        end
    end

endmodule

// ==== design/l1_arbiter.sv ====
/* Fixed-priority L1 arbiter, lowest index wins; combinational, ack in the push cycle.
   Only the data cache may store; read returns are always accepted. */
module l1_arbiter (
    input  logic [l2_pkg::L1_CONNECTIONS-1:0] request,
    input  l2_pkg::l1_request_array_t         l1_req,
    output logic [l2_pkg::L1_CONNECTIONS-1:0] ack,

    // Request and write-data FIFO side
    input  logic                              request_full,
    input  logic                              data_full,
    output logic                              request_push,
    output l2_pkg::l2_request_t               l2_req,
    output logic                              wr_data_push,
    output logic [l2_pkg::DATA_W-1:0]         wr_data,

    // Return side from memory
    input  logic                              rd_valid,
    input  l2_pkg::l2_return_t                rd_return,
    output logic [l2_pkg::L1_CONNECTIONS-1:0] data_valid,
    output logic [l2_pkg::DATA_W-1:0]         data
);
    import l2_pkg::*;

    // Every requester already mapped to FIFO format
    l2_request_t [L1_CONNECTIONS-1:0] l2_requests;

    // Winning requester index
    logic [SUB_ID_W-1:0] arb_sel;

    logic fifos_full;
    logic request_exists;

    ////////////////////
    // Request mapping

    // Drop the byte offset, tag with own index
    generate
        for (genvar i = 0; i < L1_CONNECTIONS; i++) begin : gen_l2_requests
            assign l2_requests[i] = '{
                addr   : l1_req[i].addr[ADDR_W-1:2],
                rnw    : l1_req[i].rnw,
                be     : l1_req[i].be,
                sub_id : SUB_ID_W'(i)
            };
        end
    endgenerate

    ////////////////////
    // Arbitration

    // Priority encoder, scanned downward so the lowest set index is kept
    always_comb begin
        arb_sel = '0;
        for (int i = L1_CONNECTIONS - 1; i >= 0; i--) begin
            if (request[i]) begin
                arb_sel = SUB_ID_W'(i);
            end
        end
    end

    // FIFOs drain at different rates, so both must have room
    assign fifos_full = request_full | data_full;
    assign request_exists = |request;
    assign request_push = request_exists & ~fifos_full;

    // One-hot ack for the winner, only when the push happens
    assign ack = L1_CONNECTIONS'(request_push) << arb_sel;

    assign l2_req = l2_requests[arb_sel];

    ////////////////////
    // Data cache stores

    // Write word goes along only for a winning data-cache store
    assign wr_data_push = request_push & (arb_sel == SUB_ID_W'(L1_DCACHE_ID))
                        & ~l1_req[L1_DCACHE_ID].rnw;
    assign wr_data = l1_req[L1_DCACHE_ID].data;

    ////////////////////
    // Return routing

    // Data fans out to all, valid only where the tag matches
    assign data = rd_return.data;
    generate
        for (genvar i = 0; i < L1_CONNECTIONS; i++) begin : gen_returns
            assign data_valid[i] = rd_valid & (rd_return.sub_id == SUB_ID_W'(i));
        end
    endgenerate

endmodule

// ==== design/l2_fifo.sv ====
/* Synchronous FIFO of FIFO_DEPTH entries; push while full is dropped unless popped
   in the same cycle. A pushed entry reaches the head one cycle later. */
module l2_fifo #(
    parameter type payload_t = logic [l2_pkg::DATA_W-1:0]
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     push,
    input  payload_t push_data,
    output logic     full,

    input  logic     pop,
    output logic     valid,
    output payload_t pop_data
);
    import l2_pkg::*;

    // Entry storage, no reset needed
    payload_t storage [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    // Occupancy, counts up to FIFO_DEPTH inclusive
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;

    logic do_push;
    logic do_pop;

    ////////////////////
    // Handshake qualification

    // Pop only when something is there
    assign do_pop = pop & valid;
    // Full FIFO still takes a push if the head leaves this cycle
    assign do_push = push & (~full | do_pop);

    // Flags straight from the count
    assign valid = (count != '0);
    assign full = (count == FIFO_DEPTH[$bits(count)-1:0]);

    // Head entry
    assign pop_data = storage[rd_ptr];

    ////////////////////
    // Pointers and count

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                // Explicit wrap for non power-of-two depths
                wr_ptr <= (wr_ptr == $bits(wr_ptr)'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == $bits(rd_ptr)'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Storage write

    always_ff @(posedge clk) begin
        if (do_push) begin
            storage[wr_ptr] <= push_data;
        end
    end

endmodule

// ==== design/l2_pkg.sv ====
/* Shared widths, requester ids and request/return records for the L2 subsystem.
   Two requesters only; one-bit sub id and single-word accesses assumed. */
package l2_pkg;

    ////////////////////
    // Requester ids

    // Number of L1 requesters sharing the L2 port
    localparam int L1_CONNECTIONS = 2;
    // Data cache wins every tie
    localparam int L1_DCACHE_ID = 0;
    // Instruction cache, read only
    localparam int L1_ICACHE_ID = 1;

    ////////////////////
    // Widths

    // Byte address from the L1 side
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // One enable per byte lane
    localparam int BE_W = DATA_W / 8;
    // Enough to tag every requester
    localparam int SUB_ID_W = 1;
    // Word index into the L2 array, 256 words
    localparam int MEM_ADDR_W = 8;
    // Shared by the request and write-data FIFOs
    localparam int FIFO_DEPTH = 4;

    ////////////////////
    // Records

    // One requester's bundle, valid travels beside it
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              rnw;
        logic [BE_W-1:0]   be;
        // Store word, ignored on reads
        logic [DATA_W-1:0] data;
    } l1_request_t;

    // Top-level bundle, indexed by requester id
    typedef l1_request_t [L1_CONNECTIONS-1:0] l1_request_array_t;

    // Request FIFO entry, word address only
    typedef struct packed {
        logic [ADDR_W-3:0]   addr;
        logic                rnw;
        logic [BE_W-1:0]     be;
        // Requester that issued it
        logic [SUB_ID_W-1:0] sub_id;
    } l2_request_t;

    // Read return, qualified by a separate valid
    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [SUB_ID_W-1:0] sub_id;
    } l2_return_t;

endpackage
